// File: filelist.f
rtl/fetch_isa_pkg.sv
rtl/fetch_cfg_pkg.sv
rtl/fetch_cfg_regs.sv
rtl/imem_banked.sv
rtl/fetch.sv
rtl/fetch_top.sv
verification/fetch_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = fetch_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
PASS_MSG   = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/fetch_tb.sv
module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned tb_seed = 32'h785ed15a;
  localparam int load_words = 128;
  localparam int run_cycles = 1500;
  localparam int reset_cycles = 3;
  // Load phases, three random run phases, resets and directed traps
  localparam int timeout_cycles = 3 * (load_words + 4) + 3 * run_cycles + 200;

  // Halfword index into the model memory at the imem halfword address width
  typedef logic [fetch_cfg_pkg::imem_aw-1:0] hw_idx_t;
  localparam int hw_depth = fetch_cfg_pkg::imem_words * 2;

  // DUT inputs
  logic                    bus;
  logic                    rst_n;
  logic                    host_wr;
  logic                    host_rd;
  fetch_cfg_pkg::cfg_reg_e host_reg;
  fetch_isa_pkg::addr_t    host_wdata;
  logic                    pc_en;
  logic                    stall;
  logic                    branch;
  logic                    jal;
  logic                    jalr;
  fetch_isa_pkg::addr_t    branch_off;
  logic                    trigger_trap;
  logic                    trap_ret;
  fetch_isa_pkg::addr_t    mepc;
  // DUT outputs
  fetch_isa_pkg::addr_t    host_rdata;
  fetch_isa_pkg::addr_t    pres_addr;
  fetch_isa_pkg::ins_t     ins;
  logic                    comp;

  // Reference model state
  fetch_isa_pkg::halfword_t m_mem [hw_depth];
  fetch_isa_pkg::addr_t     m_pc;
  fetch_isa_pkg::addr_t     m_target;
  fetch_isa_pkg::addr_t     m_mtvec;
  fetch_isa_pkg::addr_t     m_ptr;
  fetch_isa_pkg::ins_t      m_data;
  logic                     m_bubble;
  logic                     m_redir;
  logic                     m_prog;
  logic                     m_halt;

  int error_count;
  int check_count;
  int cycle_count;
  int unsigned seed_ret;

  fetch_top dut0 (.*);

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  ////////////////////
  // Model
  ////////////////////

  function automatic hw_idx_t hw_index(fetch_isa_pkg::addr_t a);
    return a[fetch_cfg_pkg::imem_aw:1];
  endfunction

  // 32-bit read at any halfword that wraps at the top of memory
  function automatic fetch_isa_pkg::ins_t word_at(fetch_isa_pkg::addr_t a);
    return {m_mem[hw_index(a + fetch_isa_pkg::addr_t'(2))], m_mem[hw_index(a)]};
  endfunction

  // RVC parcel unless low bits are 11 or the word is all zero
  function automatic logic is_comp(fetch_isa_pkg::ins_t w);
    return (w[1:0] != 2'b11) && (w != '0);
  endfunction

  // Memory keeps its contents, as do the last loaded word and redirect target
  task automatic model_reset();
    m_pc     = fetch_isa_pkg::reset_pc;
    m_bubble = 1'b1;
    m_redir  = 1'b0;
    m_prog   = 1'b0;
    m_halt   = 1'b0;
    m_mtvec  = '0;
    m_ptr    = '0;
  endtask

  // One rising edge with the inputs as the DUT samples them
  task automatic model_edge();
    logic                 en;
    logic                 c;
    fetch_isa_pkg::addr_t step;
    fetch_isa_pkg::addr_t nxt;
    if (!rst_n) begin
      model_reset();
    end else begin
      en = pc_en && !m_halt && !m_prog && !stall;
      c = !m_bubble && is_comp(word_at(m_pc));
      if (m_bubble) step = '0;
      else if (c) step = fetch_isa_pkg::cins_step;
      else step = fetch_isa_pkg::ins_step;
      // trap_ret, then trap, then a pending redirect
      if (trap_ret) nxt = mepc;
      else if (trigger_trap) nxt = m_mtvec;
      else if (m_redir) nxt = m_target;
      else nxt = m_pc + step;
      if (m_prog) begin
        m_pc     = fetch_isa_pkg::reset_pc;
        m_bubble = 1'b1;
        m_redir  = 1'b0;
      end else if (en) begin
        m_target = jalr ? branch_off : m_pc + branch_off;
        m_redir  = branch || jal || jalr;
        m_pc     = nxt;
        m_bubble = 1'b0;
      end
      // Host register writes land on the same edge
      if (host_wr) begin
        case (host_reg)
          fetch_cfg_pkg::ctrl: begin
            m_prog = host_wdata[fetch_cfg_pkg::ctrl_prog_bit];
            m_halt = host_wdata[fetch_cfg_pkg::ctrl_halt_bit];
          end
          fetch_cfg_pkg::mtvec:     m_mtvec = host_wdata;
          fetch_cfg_pkg::load_addr: m_ptr = host_wdata;
          fetch_cfg_pkg::load_data: begin
            // Words outside program mode are dropped
            if (m_prog) begin
              m_mem[hw_index(m_ptr)] = host_wdata[15:0];
              m_mem[hw_index(m_ptr + fetch_isa_pkg::addr_t'(2))] = host_wdata[31:16];
              m_data = host_wdata;
              m_ptr = m_ptr + fetch_isa_pkg::ins_step;
            end
          end
        endcase
      end
    end
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_addr(string name, fetch_isa_pkg::addr_t got, fetch_isa_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_ins(string name, fetch_isa_pkg::ins_t got, fetch_isa_pkg::ins_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_outputs();
    fetch_isa_pkg::ins_t  w;
    fetch_isa_pkg::ins_t  exp_ins;
    fetch_isa_pkg::addr_t exp_rd;
    logic                 exp_comp;
    w = word_at(m_pc);
    exp_comp = !m_bubble && is_comp(w);
    if (m_bubble) exp_ins = '0;
    else if (exp_comp) exp_ins = fetch_isa_pkg::ins_t'(w[15:0]);
    else exp_ins = w;
    // Host read data is combinational from the selected register
    exp_rd = '0;
    if (host_rd) begin
      case (host_reg)
        fetch_cfg_pkg::ctrl: begin
          exp_rd[fetch_cfg_pkg::ctrl_prog_bit] = m_prog;
          exp_rd[fetch_cfg_pkg::ctrl_halt_bit] = m_halt;
        end
        fetch_cfg_pkg::mtvec:     exp_rd = m_mtvec;
        fetch_cfg_pkg::load_addr: exp_rd = m_ptr;
        fetch_cfg_pkg::load_data: exp_rd = m_data;
      endcase
    end
    check_addr("pres_addr", pres_addr, m_pc);
    check_ins("ins", ins, exp_ins);
    check_bit("comp", comp, exp_comp);
    check_addr("host_rdata", host_rdata, exp_rd);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Model step and then strobes back to idle for the caller to override
  task automatic clock_edge();
    @(posedge bus);
    model_edge();
    host_wr      <= 1'b0;
    host_rd      <= 1'b0;
    branch       <= 1'b0;
    jal          <= 1'b0;
    jalr         <= 1'b0;
    trigger_trap <= 1'b0;
    trap_ret     <= 1'b0;
  endtask

  // Outputs are stable at the falling edge
  task automatic settle_check();
    @(negedge bus);
    check_outputs();
  endtask

  // Release lands with the last of the reset edges
  task automatic hold_reset();
    repeat (reset_cycles - 1) begin
      clock_edge();
      settle_check();
    end
    clock_edge();
    rst_n <= 1'b1;
    settle_check();
  endtask

  task automatic host_write(fetch_cfg_pkg::cfg_reg_e r, fetch_isa_pkg::addr_t d);
    clock_edge();
    host_wr    <= 1'b1;
    host_reg   <= r;
    host_wdata <= d;
    settle_check();
  endtask

  task automatic host_read_check(fetch_cfg_pkg::cfg_reg_e r, fetch_isa_pkg::addr_t exp);
    clock_edge();
    host_rd  <= 1'b1;
    host_reg <= r;
    settle_check();
    check_addr("host_rdata", host_rdata, exp);
  endtask

  // Program mode, pointer, random words, pointer readback, run mode
  task automatic load_program(fetch_isa_pkg::addr_t start, int n);
    fetch_isa_pkg::ins_t w;
    host_write(fetch_cfg_pkg::ctrl, fetch_isa_pkg::addr_t'(1) << fetch_cfg_pkg::ctrl_prog_bit);
    host_write(fetch_cfg_pkg::load_addr, start);
    for (int i = 0; i < n; i++) begin
      w = $urandom;
      // About half full-length encodings
      if ($urandom % 2 == 0) w[1:0] = 2'b11;
      host_write(fetch_cfg_pkg::load_data, w);
    end
    host_read_check(fetch_cfg_pkg::load_addr,
                    start + fetch_isa_pkg::addr_t'(n) * fetch_isa_pkg::ins_step);
    host_write(fetch_cfg_pkg::ctrl, '0);
  endtask

  task automatic directed_traps();
    fetch_isa_pkg::addr_t vec;
    fetch_isa_pkg::addr_t ret;
    vec = $urandom & 32'h0000_07fe;
    ret = $urandom & 32'h0000_07fe;
    host_write(fetch_cfg_pkg::mtvec, vec);
    clock_edge();
    pc_en        <= 1'b1;
    stall        <= 1'b0;
    trigger_trap <= 1'b1;
    settle_check();
    clock_edge();
    settle_check();
    check_addr("pres_addr", pres_addr, vec);
    // trap_ret takes mepc when both are high
    clock_edge();
    trigger_trap <= 1'b1;
    trap_ret     <= 1'b1;
    mepc         <= ret;
    settle_check();
    clock_edge();
    settle_check();
    check_addr("pres_addr", pres_addr, ret);
  endtask

  task automatic run_random(int n);
    int unsigned          sel;
    int unsigned          hsel;
    fetch_isa_pkg::addr_t off;
    logic [1:0]           rsel;
    for (int i = 0; i < n; i++) begin
      clock_edge();
      sel  = $urandom % 16;
      hsel = $urandom % 32;
      rsel = 2'($urandom);
      off  = $urandom & 32'h0000_03fe;
      if ($urandom % 2 == 0) off = -off;
      pc_en        <= ($urandom % 8) != 0;
      stall        <= ($urandom % 8) == 0;
      branch_off   <= off;
      trigger_trap <= ($urandom % 40) == 0;
      trap_ret     <= ($urandom % 40) == 0;
      mepc         <= $urandom & 32'h0000_07fe;
      if (sel == 0) branch <= 1'b1;
      else if (sel == 1) jal <= 1'b1;
      else if (sel == 2) jalr <= 1'b1;
      // Occasional host writes and otherwise a register read
      case (hsel)
        0: begin
          host_wr    <= 1'b1;
          host_reg   <= fetch_cfg_pkg::ctrl;
          host_wdata <= ($urandom % 3 == 0) ?
                        fetch_isa_pkg::addr_t'(1) << fetch_cfg_pkg::ctrl_halt_bit : '0;
        end
        1: begin
          host_wr    <= 1'b1;
          host_reg   <= fetch_cfg_pkg::mtvec;
          host_wdata <= $urandom & 32'h0000_07fe;
        end
        2: begin
          host_wr    <= 1'b1;
          host_reg   <= fetch_cfg_pkg::load_addr;
          host_wdata <= $urandom & 32'h0000_07fc;
        end
        3: begin
          // Ignored outside program mode
          host_wr    <= 1'b1;
          host_reg   <= fetch_cfg_pkg::load_data;
          host_wdata <= $urandom;
        end
        default: begin
          host_rd  <= 1'b1;
          host_reg <= fetch_cfg_pkg::cfg_reg_e'(rsel);
        end
      endcase
      settle_check();
    end
  endtask

  // Reset lands between clock edges
  task automatic async_reset();
    #2;
    rst_n <= 1'b0;
    #1;
    model_reset();
    check_outputs();
    hold_reset();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed_ret = $urandom(tb_seed);
    error_count = 0;
    check_count = 0;
    rst_n        <= 1'b0;
    host_wr      <= 1'b0;
    host_rd      <= 1'b0;
    host_reg     <= fetch_cfg_pkg::ctrl;
    host_wdata   <= '0;
    pc_en        <= 1'b0;
    stall        <= 1'b0;
    branch       <= 1'b0;
    jal          <= 1'b0;
    jalr         <= 1'b0;
    branch_off   <= '0;
    trigger_trap <= 1'b0;
    trap_ret     <= 1'b0;
    mepc         <= '0;
    model_reset();
    hold_reset();
    // Two halves fill the whole memory
    load_program('0, load_words);
    load_program(fetch_isa_pkg::addr_t'(load_words) * fetch_isa_pkg::ins_step, load_words);
    directed_traps();
    run_random(run_cycles);
    async_reset();
    run_random(run_cycles);
    // Reprogram mid-run repeats the bubble
    load_program('0, load_words);
    run_random(run_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge bus);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// File: rtl/fetch_top.sv
module fetch_top (
  input  logic                    bus,
  input  logic                    rst_n,
  // Host register port
  input  logic                    host_wr,
  input  logic                    host_rd,
  input  fetch_cfg_pkg::cfg_reg_e host_reg,
  input  fetch_isa_pkg::addr_t    host_wdata,
  output fetch_isa_pkg::addr_t    host_rdata,
  // Core controls
  input  logic                    pc_en,
  input  logic                    stall,
  input  logic                    branch,
  input  logic                    jal,
  input  logic                    jalr,
  input  fetch_isa_pkg::addr_t    branch_off,
  input  logic                    trigger_trap,
  input  logic                    trap_ret,
  input  fetch_isa_pkg::addr_t    mepc,
  // Fetch results
  output fetch_isa_pkg::addr_t    pres_addr,
  output fetch_isa_pkg::ins_t     ins,
  output logic                    comp
);

  // Config block to fetch
  logic                 prog;
  logic                 halt;
  fetch_isa_pkg::addr_t mtvec;
  // Config block to imem write port
  logic                 load_we;
  fetch_isa_pkg::addr_t load_addr;
  fetch_isa_pkg::ins_t  load_data;
  // Fetch to imem read port
  logic                 rd_en;
  fetch_isa_pkg::addr_t rd_addr;
  fetch_isa_pkg::ins_t  rd_data;

  fetch_cfg_regs cfg0 (
    .bus        (bus),
    .rst_n      (rst_n),
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .host_reg   (host_reg),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .prog       (prog),
    .halt       (halt),
    .mtvec      (mtvec),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  fetch fetch0 (
    .bus          (bus),
    .rst_n        (rst_n),
    .pc_en        (pc_en),
    .stall        (stall),
    .halt         (halt),
    .prog         (prog),
    .branch       (branch),
    .jal          (jal),
    .jalr         (jalr),
    .branch_off   (branch_off),
    .trigger_trap (trigger_trap),
    .trap_ret     (trap_ret),
    .mepc         (mepc),
    .mtvec        (mtvec),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .pres_addr    (pres_addr),
    .ins          (ins),
    .comp         (comp)
  );

  imem_banked imem0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .we      (load_we),
    .wr_addr (load_addr),
    .wr_data (load_data)
  );

endmodule

// File: rtl/fetch.sv
module fetch (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 pc_en,
  input  logic                 stall,
  input  logic                 halt,
  input  logic                 prog,
  input  logic                 branch,
  input  logic                 jal,
  input  logic                 jalr,
  input  fetch_isa_pkg::addr_t branch_off,
  input  logic                 trigger_trap,
  input  logic                 trap_ret,
  input  fetch_isa_pkg::addr_t mepc,
  input  fetch_isa_pkg::addr_t mtvec,
  output logic                 rd_en,
  output fetch_isa_pkg::addr_t rd_addr,
  input  fetch_isa_pkg::ins_t  rd_data,
  output fetch_isa_pkg::addr_t pres_addr,
  output fetch_isa_pkg::ins_t  ins,
  output logic                 comp
);

  logic                     fetch_en;
  // Set out of reset and during program mode
  logic                     bubble_q;
  // Redirect seen on the last enabled edge
  logic                     redirect_q;
  fetch_isa_pkg::addr_t     redirect_addr_q;
  fetch_isa_pkg::addr_t     pc_step;
  fetch_isa_pkg::addr_t     seq_addr;
  fetch_isa_pkg::addr_t     next_addr;
  fetch_isa_pkg::pc_src_e   pc_src;
  fetch_isa_pkg::halfword_t lo_half;

  // Any hold source freezes PC and imem output together
  assign fetch_en = pc_en && !halt && !prog && !stall;

  ////////////////////
  // Compressed decode
  ////////////////////

  // RVC parcels have low bits other than 11
  // An all-zero word is illegal and treated as full length
  assign comp    = !bubble_q && (rd_data[1:0] != 2'b11) && (rd_data != '0);
  assign lo_half = rd_data[15:0];

  // Bubble keeps stale imem data off the output
  always_comb begin
    if (bubble_q) begin
      ins = '0;
    end else if (comp) begin
      ins = fetch_isa_pkg::ins_t'(lo_half);
    end else begin
      ins = rd_data;
    end
  end

  ////////////////////
  // Next address
  ////////////////////

  always_comb begin
    if (bubble_q) begin
      pc_step = '0;
    end else if (comp) begin
      pc_step = fetch_isa_pkg::cins_step;
    end else begin
      pc_step = fetch_isa_pkg::ins_step;
    end
  end

  assign seq_addr = pres_addr + pc_step;

  // trap_ret wins over trigger_trap, both win over a redirect
  always_comb begin
    if (trap_ret) begin
      pc_src = fetch_isa_pkg::trap_ret;
    end else if (trigger_trap) begin
      pc_src = fetch_isa_pkg::trap;
    end else if (redirect_q) begin
      pc_src = fetch_isa_pkg::redirect;
    end else begin
      pc_src = fetch_isa_pkg::seq;
    end
  end

  always_comb begin
    unique case (pc_src)
      fetch_isa_pkg::seq:      next_addr = seq_addr;
      fetch_isa_pkg::redirect: next_addr = redirect_addr_q;
      fetch_isa_pkg::trap:     next_addr = mtvec;
      fetch_isa_pkg::trap_ret: next_addr = mepc;
    endcase
  end

  // imem registers the word at next_addr on the same edge as the PC
  assign rd_en   = fetch_en;
  assign rd_addr = next_addr;

  ////////////////////
  // PC and redirect state
  ////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      pres_addr  <= fetch_isa_pkg::reset_pc;
      bubble_q   <= 1'b1;
      redirect_q <= 1'b0;
    end else if (prog) begin
      // Program mode parks fetch in its reset state
      pres_addr  <= fetch_isa_pkg::reset_pc;
      bubble_q   <= 1'b1;
      redirect_q <= 1'b0;
    end else if (fetch_en) begin
      pres_addr  <= next_addr;
      bubble_q   <= 1'b0;
      redirect_q <= branch || jal || jalr;
    end
  end

  // jalr target comes in absolute, branch and jal are PC relative
  always_ff @(posedge bus) begin
    if (fetch_en) begin
      if (jalr) begin
        redirect_addr_q <= branch_off;
      end else begin
        redirect_addr_q <= pres_addr + branch_off;
      end
    end
  end

  // Offsets, mtvec and mepc from outside must keep the PC on parcels
  a_pc_aligned: assert property (@(posedge bus) disable iff (!rst_n)
    pres_addr[0] == 1'b0);

endmodule

// File: rtl/imem_banked.sv
module imem_banked (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 rd_en,
  input  fetch_isa_pkg::addr_t rd_addr,
  output fetch_isa_pkg::ins_t  rd_data,
  input  logic                 we,
  input  fetch_isa_pkg::addr_t wr_addr,
  input  fetch_isa_pkg::ins_t  wr_data
);

  // Even bank holds bits 15:0 of each word, odd bank bits 31:16
  fetch_isa_pkg::halfword_t even_bank [fetch_cfg_pkg::imem_words];
  fetch_isa_pkg::halfword_t odd_bank  [fetch_cfg_pkg::imem_words];

  fetch_cfg_pkg::imem_idx_t rd_idx;
  fetch_cfg_pkg::imem_idx_t rd_idx_next;
  fetch_cfg_pkg::imem_idx_t wr_idx;
  logic                     rd_odd;
  fetch_isa_pkg::halfword_t rd_lo;
  fetch_isa_pkg::halfword_t rd_hi;

  assign rd_idx      = rd_addr[fetch_cfg_pkg::imem_aw:2];
  assign rd_odd      = rd_addr[1];
  // Wraps at the top of memory
  assign rd_idx_next = rd_idx + fetch_cfg_pkg::imem_idx_t'(1);
  assign wr_idx      = wr_addr[fetch_cfg_pkg::imem_aw:2];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge bus) begin
    if (we) begin
      even_bank[wr_idx] <= wr_data[15:0];
      odd_bank[wr_idx]  <= wr_data[31:16];
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Odd start takes its upper half from the next even row
  always_comb begin
    if (rd_odd) begin
      rd_lo = odd_bank[rd_idx];
      rd_hi = even_bank[rd_idx_next];
    end else begin
      rd_lo = even_bank[rd_idx];
      rd_hi = odd_bank[rd_idx];
    end
  end

  // Holds the last word while reads are off
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= {rd_hi, rd_lo};
    end
  end

  // Load pointer from the host must stay on word boundaries
  a_wr_aligned: assert property (@(posedge bus) disable iff (!rst_n)
    we |-> (wr_addr[1:0] == 2'b00));

endmodule

// File: rtl/fetch_cfg_regs.sv
module fetch_cfg_regs (
  input  logic                    bus,
  input  logic                    rst_n,
  input  logic                    host_wr,
  input  logic                    host_rd,
  input  fetch_cfg_pkg::cfg_reg_e host_reg,
  input  fetch_isa_pkg::addr_t    host_wdata,
  output fetch_isa_pkg::addr_t    host_rdata,
  output logic                    prog,
  output logic                    halt,
  output fetch_isa_pkg::addr_t    mtvec,
  output logic                    load_we,
  output fetch_isa_pkg::addr_t    load_addr,
  output fetch_isa_pkg::ins_t     load_data
);

  // Control bits, indexed by the ctrl bit positions
  logic [1:0]           ctrl_q;
  fetch_isa_pkg::addr_t mtvec_q;
  // Auto-incrementing program load pointer
  fetch_isa_pkg::addr_t load_ptr_q;
  // Address and data that go with the imem write pulse
  fetch_isa_pkg::addr_t load_addr_q;
  fetch_isa_pkg::ins_t  load_data_q;
  logic                 load_we_q;
  // Decoded write strobes
  logic                 wr_ctrl;
  logic                 wr_mtvec;
  logic                 wr_ptr;
  logic                 wr_word;

  assign wr_ctrl  = host_wr && (host_reg == fetch_cfg_pkg::ctrl);
  assign wr_mtvec = host_wr && (host_reg == fetch_cfg_pkg::mtvec);
  assign wr_ptr   = host_wr && (host_reg == fetch_cfg_pkg::load_addr);
  // Program words are only taken in program mode
  assign wr_word  = host_wr && (host_reg == fetch_cfg_pkg::load_data) && prog;

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q     <= '0;
      mtvec_q    <= '0;
      load_ptr_q <= '0;
      load_we_q  <= 1'b0;
    end else begin
      // Strobe lasts exactly one cycle
      load_we_q <= wr_word;
      if (wr_ctrl) begin
        ctrl_q[fetch_cfg_pkg::ctrl_prog_bit] <= host_wdata[fetch_cfg_pkg::ctrl_prog_bit];
        ctrl_q[fetch_cfg_pkg::ctrl_halt_bit] <= host_wdata[fetch_cfg_pkg::ctrl_halt_bit];
      end
      if (wr_mtvec) begin
        mtvec_q <= host_wdata;
      end
      // Pointer moves one word per loaded instruction
      if (wr_ptr) begin
        load_ptr_q <= host_wdata;
      end else if (wr_word) begin
        load_ptr_q <= load_ptr_q + fetch_isa_pkg::ins_step;
      end
    end
  end

  // Write payload captured with the old pointer
  always_ff @(posedge bus) begin
    if (wr_word) begin
      load_addr_q <= load_ptr_q;
      load_data_q <= host_wdata;
    end
  end

  ////////////////////
  // Host read mux
  ////////////////////

  always_comb begin
    host_rdata = '0;
    if (host_rd) begin
      unique case (host_reg)
        fetch_cfg_pkg::ctrl:      host_rdata = fetch_isa_pkg::addr_t'(ctrl_q);
        fetch_cfg_pkg::mtvec:     host_rdata = mtvec_q;
        fetch_cfg_pkg::load_addr: host_rdata = load_ptr_q;
        fetch_cfg_pkg::load_data: host_rdata = load_data_q;
      endcase
    end
  end

  assign prog      = ctrl_q[fetch_cfg_pkg::ctrl_prog_bit];
  assign halt      = ctrl_q[fetch_cfg_pkg::ctrl_halt_bit];
  assign mtvec     = mtvec_q;
  assign load_we   = load_we_q;
  assign load_addr = load_addr_q;
  assign load_data = load_data_q;

  // No imem write may land outside program mode
  a_load_we_in_prog: assert property (@(posedge bus) disable iff (!rst_n)
    load_we |-> prog);

endmodule

// File: rtl/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

  ////////////////////
  // Host register map
  ////////////////////

  // Two-bit register select from the host port
  typedef enum logic [1:0] {
    ctrl      = 2'd0,
    mtvec     = 2'd1,
    load_addr = 2'd2,
    load_data = 2'd3
  } cfg_reg_e;

  // Bit positions inside ctrl
  localparam int ctrl_prog_bit = 0;
  localparam int ctrl_halt_bit = 1;

  ////////////////////
  // Instruction memory
  ////////////////////

  // Depth in 32-bit words
  localparam int imem_words = 256;

  // Halfword address width, byte address bits [imem_aw:1]
  localparam int imem_aw = $clog2(imem_words * 2);

  // Row index into one bank, byte address bits [imem_aw:2]
  typedef logic [imem_aw-2:0] imem_idx_t;

endpackage

// File: rtl/fetch_isa_pkg.sv
package fetch_isa_pkg;

  ////////////////////
  // Datapath widths
  ////////////////////

  // Architectural register and address width
  localparam int xlen = 32;

  // One compressed parcel, also the width of an imem bank entry
  localparam int parcel_width = 16;

  ////////////////////
  // Types
  ////////////////////

  // Byte address of an instruction
  typedef logic [xlen-1:0] addr_t;

  // Raw or zero-extended instruction word
  typedef logic [xlen-1:0] ins_t;

  // Entry of one instruction memory bank
  typedef logic [parcel_width-1:0] halfword_t;

  // Where the next PC comes from
  // Listed from lowest to highest priority
  typedef enum logic [1:0] {
    seq,
    redirect,
    trap,
    trap_ret
  } pc_src_e;

  ////////////////////
  // PC constants
  ////////////////////

  // Full-length instruction step
  localparam addr_t ins_step = 32'd4;

  // Compressed instruction step
  localparam addr_t cins_step = 32'd2;

  // First fetch address out of reset
  localparam addr_t reset_pc = 32'd0;

endpackage
